// ==== Makefile ====
# Verilator flow for the Spectrum bus core testbench
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module tb_zx_bus

run: build
	./obj_dir/Vtb_zx_bus | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module zx_bus_top

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
verilog/zx_pkg.sv
verilog/port_decode.sv
verilog/paging_regs.sv
verilog/sound_regs.sv
verilog/mem_map.sv
verilog/zx_bus_top.sv
testbench/tb_clock.sv
testbench/zx_bus_assert.sv
testbench/tb_zx_bus.sv

// ==== testbench/tb_clock.sv ====
//====================================================================
// Testbench clock and reset, 100 ns period
// Power-on reset covers two rising edges, reset_req adds more
//====================================================================
module tb_clock (
	input  logic reset_req,
	output logic clk_sys,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ns;

	logic por;  // Power-on part

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Released on a falling edge, away from the sampling edge
	initial begin
		por = 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		por = 1'b0;
	end

	assign reset = por | reset_req;

endmodule

// ==== testbench/tb_zx_bus.sv ====
//====================================================================
// Testbench for the bus core that replays testbench/zx_bus_golden.txt
// R resets with a mode while W writes a port and M writes memory
//====================================================================
module tb_zx_bus;
	timeunit 1ns;
	timeprecision 1ns;

	logic                  clk_sys;
	logic                  reset;
	logic                  reset_req;
	zx_pkg::cpu_bus_t      bus;
	zx_pkg::mem_mode_e     mem_mode;
	zx_pkg::sdram_addr_t   ram_addr;
	logic                  ram_we;
	zx_pkg::ula_out_t      ula;
	zx_pkg::audio_sample_t audio_l;
	zx_pkg::audio_sample_t audio_r;

	// Fields of the current golden line
	string       v_name;
	string       v_op;
	logic [15:0] v_addr;
	logic [7:0]  v_data;
	logic [23:0] v_ram_addr;
	logic        v_we;
	logic [4:0]  v_ula;
	logic [14:0] v_audio_l;
	logic [14:0] v_audio_r;

	tb_clock u_clock (
		.reset_req (reset_req),
		.clk_sys   (clk_sys),
		.reset     (reset)
	);

	zx_bus_top #(.ROM_BASE(24'h200000)) DUT (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bus      (bus),
		.mem_mode (mem_mode),
		.ram_addr (ram_addr),
		.ram_we   (ram_we),
		.ula      (ula),
		.audio_l  (audio_l),
		.audio_r  (audio_r)
	);

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped");
	endtask

	//================================================================
	// Compare tasks
	//================================================================
	task automatic check_addr(input string name, input zx_pkg::sdram_addr_t exp,
			input zx_pkg::sdram_addr_t act);
		if (act !== exp)
			fail_now($sformatf("ERR %s ram_addr expected %h actual %h", name, exp, act));
	endtask

	task automatic check_we(input string name, input bit exp, input bit act);
		if (act !== exp)
			fail_now($sformatf("ERR %s ram_we expected %b actual %b", name, exp, act));
	endtask

	task automatic check_ula(input string name, input zx_pkg::ula_out_t exp,
			input zx_pkg::ula_out_t act);
		if (act !== exp)
			fail_now($sformatf("ERR %s ula expected %h actual %h", name, exp, act));
	endtask

	task automatic check_audio(input string name, input zx_pkg::audio_sample_t exp,
			input zx_pkg::audio_sample_t act);
		if (act !== exp)
			fail_now($sformatf("ERR %s expected %h actual %h", name, exp, act));
	endtask

	//================================================================
	// Waits and operations start and end on a falling edge
	//================================================================
	task automatic next_cycles(input int count);
		for (int i = 0; i < count; i++)
			@(negedge clk_sys);
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (reset) begin
			if (cycles == 8)
				fail_now("Timeout: reset was never released");
			@(negedge clk_sys);
			cycles++;
		end
	endtask

	task automatic check_sound();
		check_audio({v_name, " audio_l"}, v_audio_l, audio_l);
		check_audio({v_name, " audio_r"}, v_audio_r, audio_r);
	endtask

	task automatic apply_reset();
		mem_mode  = zx_pkg::mem_mode_e'(v_data[1:0]);
		reset_req = 1'b1;
		bus       = '0;
		bus.addr  = v_addr;
		next_cycles(2);                      // Two rising edges in reset
		reset_req = 1'b0;
		wait_reset_release();
		check_addr(v_name, v_ram_addr, ram_addr);
		check_we(v_name, v_we, ram_we);
		check_ula(v_name, v_ula, ula);
		check_sound();
	endtask

	task automatic write_port();
		bus       = '0;
		bus.addr  = v_addr;
		bus.data  = v_data;
		bus.io_wr = 1'b1;
		next_cycles(1);                      // Latches load on the strobe edge
		check_ula(v_name, v_ula, ula);
		next_cycles(1);                      // Then the samples
		check_sound();
		bus.io_wr = 1'b0;
		next_cycles(1);                      // Gap so the next write is new
	endtask

	task automatic write_memory();
		bus      = '0;
		bus.addr = v_addr;
		bus.data = v_data;
		bus.mreq = 1'b1;
		bus.wr   = 1'b1;
		next_cycles(1);
		check_addr(v_name, v_ram_addr, ram_addr);
		check_we(v_name, v_we, ram_we);
		bus.mreq = 1'b0;
		bus.wr   = 1'b0;
	endtask

	initial begin
		string line;
		int    fd;
		int    fields;
		bus       = '0;
		mem_mode  = zx_pkg::MODE_128;
		reset_req = 1'b0;
		fd = $fopen("testbench/zx_bus_golden.txt", "r");
		if (fd == 0)
			fail_now("Could not open the golden vector file");
		next_cycles(1);                      // Power-on reset is up by now
		wait_reset_release();
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			fields = $sscanf(line, "%s %s %h %h %h %h %h %h %h", v_name, v_op, v_addr,
				v_data, v_ram_addr, v_we, v_ula, v_audio_l, v_audio_r);
			if (fields != 9)
				fail_now({"Golden line has missing fields: ", line});
			else if (v_op == "R")
				apply_reset();
			else if (v_op == "W")
				write_port();
			else if (v_op == "M")
				write_memory();
			else
				fail_now({"Unknown operation in golden line: ", line});
		end
		$fclose(fd);
		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== testbench/zx_bus_assert.sv ====
//====================================================================
// Concurrent checks on the bus core, bound into every zx_bus_top
//====================================================================
module zx_bus_assert (
	input logic                  clk_sys,
	input logic                  reset,
	input zx_pkg::cpu_bus_t      bus,
	input zx_pkg::page_state_t   state,
	input logic                  io_strobe,
	input logic                  ram_we,
	input zx_pkg::ula_out_t      ula,
	input zx_pkg::audio_sample_t audio_l,
	input zx_pkg::audio_sample_t audio_r
);
	timeunit 1ns;
	timeprecision 1ns;

	logic rom_access;
	logic paging_locked;

	assign rom_access    = bus.mreq & (bus.addr[15:14] == 2'd0) & ~state.w1ffd.view_1ffd.special;
	assign paging_locked = ~reset &
		(state.w7ffd.view_7ffd.lock | (state.mode == zx_pkg::MODE_48));

	reset_clears: assert property (@(posedge clk_sys)
		reset |=> (ula == '0 && audio_l == '0 && audio_r == '0 && !io_strobe))
		else $error("Outputs not cleared by reset");

	rom_protect: assert property (@(posedge clk_sys) rom_access |-> !ram_we)
		else $error("Write enable on a ROM access");

	lock_holds: assert property (@(posedge clk_sys)
		paging_locked |=> $stable(state.w7ffd.raw))
		else $error("7FFD changed while paging was locked");

endmodule

bind zx_bus_top zx_bus_assert u_bus_assert (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.bus       (bus),
	.state     (state),
	.io_strobe (io_strobe),
	.ram_we    (ram_we),
	.ula       (ula),
	.audio_l   (audio_l),
	.audio_r   (audio_r)
);

// ==== testbench/zx_bus_golden.txt ====
# name op(R reset, W port write, M memory write) addr data ram_addr we ula audio_l audio_r
# R data is the mode (0 128K, 1 48K, 2 +3); W checks ula and audio, M checks ram_addr and we
reset_128   R 0000 00 200000 0 00 0000 0000
rom0_wr     M 0123 5A 200123 0 00 0000 0000
p7_rom1_b3  W 7FFD 13 000000 0 00 0000 0000
rom1_wr     M 0123 5A 204123 0 00 0000 0000
bank3_wr    M C010 5A 00C010 1 00 0000 0000
q1_bank5    M 4005 5A 014005 1 00 0000 0000
p7_lock_b6  W 7FFD 26 000000 0 00 0000 0000
bank6_wr    M C010 5A 018010 1 00 0000 0000
p7_ignored  W 7FFD 17 000000 0 00 0000 0000
still_b6    M C010 5A 018010 1 00 0000 0000
still_rom0  M 0000 5A 200000 0 00 0000 0000
reset_48    R 0000 01 20C000 0 00 0000 0000
p7_in_48    W 7FFD 14 000000 0 00 0000 0000
rom3_wr     M 1234 5A 20D234 0 00 0000 0000
bank0_wr    M C100 5A 000100 1 00 0000 0000
reset_p3    R 0000 02 210000 0 00 0000 0000
p1_rom_hi   W 1FFD 04 000000 0 00 0000 0000
p7_rom_sel  W 7FFD 10 000000 0 00 0000 0000
rom7_wr     M 0100 5A 21C100 0 00 0000 0000
sp0         W 1FFD 01 000000 0 00 0000 0000
sp0_q0      M 0010 5A 000010 1 00 0000 0000
sp0_q3      M C010 5A 00C010 1 00 0000 0000
sp1         W 1FFD 03 000000 0 00 0000 0000
sp1_q0      M 0010 5A 010010 1 00 0000 0000
sp1_q3      M C010 5A 01C010 1 00 0000 0000
sp2         W 1FFD 05 000000 0 00 0000 0000
sp2_q2      M 8010 5A 018010 1 00 0000 0000
sp2_q3      M C010 5A 00C010 1 00 0000 0000
sp3         W 1FFD 07 000000 0 00 0000 0000
sp3_q0      M 0010 5A 010010 1 00 0000 0000
sp3_q1      M 4010 5A 01C010 1 00 0000 0000
sp3_q3      M C010 5A 00C010 1 00 0000 0000
ula_fe      W 00FE 1D 000000 0 17 1800 1800
covox       W 00FB 80 000000 0 17 2800 2800
sd_a        W 000F 10 000000 0 17 2100 2800
sd_b        W 001F FF 000000 0 17 28F0 2800
sd_c        W 004F 00 000000 0 17 28F0 2000
sd_d        W 005F 40 000000 0 17 28F0 1C00
ula_quiet   W 00FE 02 000000 0 08 10F0 0400
reset_end   R 0000 00 200000 0 00 0000 0000

// ==== verilog/mem_map.sv ====
//====================================================================
// CPU address to SDRAM address translation, combinational
// ROM sits at ROM_BASE, RAM banks from address zero
//====================================================================
module mem_map #(
	parameter zx_pkg::sdram_addr_t ROM_BASE = 24'h200000
) (
	input  zx_pkg::cpu_bus_t    bus,
	input  zx_pkg::page_state_t state,
	output zx_pkg::sdram_addr_t ram_addr,
	output logic                ram_we
);

	logic [1:0]                   quarter;
	logic [zx_pkg::BANK_BITS-1:0] offset;
	logic                         special;
	logic [1:0]                   special_cfg;
	logic                         rom_area;
	logic [2:0]                   rom_num;
	logic [2:0]                   bank;

	assign quarter     = bus.addr[15:zx_pkg::BANK_BITS];
	assign offset      = bus.addr[zx_pkg::BANK_BITS-1:0];
	assign special     = state.w1ffd.view_1ffd.special;
	assign special_cfg = state.w1ffd.view_1ffd.special_cfg;
	assign rom_area    = (quarter == 2'd0) & ~special;

	//================================================================
	// ROM and bank select
	//================================================================
	always_comb begin
		case (state.mode)
			zx_pkg::MODE_48: rom_num = 3'd3;
			zx_pkg::MODE_P3: rom_num = {1'b1, special_cfg[1], state.w7ffd.view_7ffd.rom_sel};
			default:         rom_num = {2'b00, state.w7ffd.view_7ffd.rom_sel};
		endcase
	end

	always_comb begin
		if (special) begin
			case (special_cfg)
				2'd0: bank = {1'b0, quarter};              // 0 1 2 3
				2'd1: bank = {1'b1, quarter};              // 4 5 6 7
				2'd2: bank = (quarter == 2'd3) ? 3'd3 : {1'b1, quarter};
				default: begin
					case (quarter)                         // 4 7 6 3
						2'd0:    bank = 3'd4;
						2'd1:    bank = 3'd7;
						2'd2:    bank = 3'd6;
						default: bank = 3'd3;
					endcase
				end
			endcase
		end else begin
			case (quarter)
				2'd1:    bank = 3'd5;
				2'd2:    bank = 3'd2;
				2'd3:    bank = state.w7ffd.view_7ffd.bank;
				default: bank = 3'd0;                      // ROM quarter
			endcase
		end
	end

	assign ram_addr = rom_area ? ROM_BASE + zx_pkg::sdram_addr_t'({rom_num, offset})
	                           : zx_pkg::sdram_addr_t'({bank, offset});

	assign ram_we = bus.mreq & bus.wr & ~rom_area;  // ROM is write protected

endmodule

// ==== verilog/paging_regs.sv ====
//====================================================================
// Memory mode and the 7FFD / 1FFD paging registers
// Mode is sampled from the board setting while reset is held
//====================================================================
module paging_regs (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                io_strobe,
	input  zx_pkg::port_sel_t   sel,
	input  zx_pkg::page_word_u  data,
	input  zx_pkg::mem_mode_e   mem_mode,
	output zx_pkg::page_state_t state
);

	zx_pkg::mem_mode_e  mode;
	zx_pkg::page_word_u w7ffd;
	zx_pkg::page_word_u w1ffd;

	logic locked;
	logic wr_7ffd;
	logic wr_1ffd;

	//================================================================
	// Lock
	//================================================================
	// 48K never pages, otherwise the 7FFD lock bit freezes both ports
	assign locked = (mode == zx_pkg::MODE_48) | w7ffd.view_7ffd.lock;

	assign wr_7ffd = io_strobe & sel.sel_7ffd & ~locked;
	assign wr_1ffd = io_strobe & sel.sel_1ffd & ~locked;

	//================================================================
	// Registers
	//================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mode  <= mem_mode;
			w7ffd <= '0;
			w1ffd <= '0;
		end else begin
			if (wr_7ffd) begin
				w7ffd <= data;
			end
			if (wr_1ffd) begin
				w1ffd <= data;        // Only decoded in +3 mode
			end
		end
	end

	// Current paging for the address mapper
	assign state.w7ffd = w7ffd;
	assign state.w1ffd = w1ffd;
	assign state.mode  = mode;

endmodule

// ==== verilog/port_decode.sv ====
//====================================================================
// I/O write edge detect and port classification
// io_strobe marks the first cycle of each CPU port write
//====================================================================
module port_decode (
	input  logic               clk_sys,
	input  logic               reset,
	input  zx_pkg::cpu_bus_t   bus,
	input  zx_pkg::mem_mode_e  mode,
	output logic               io_strobe,
	output zx_pkg::port_sel_t  sel,
	output zx_pkg::page_word_u data
);

	logic       io_wr_prev;
	logic       is_p3;
	logic       hit_7ffd;
	logic       hit_1ffd;
	logic [7:0] low_byte;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_prev <= 1'b1;  // A write held over reset is not new
		end else begin
			io_wr_prev <= bus.io_wr;
		end
	end

	assign io_strobe = bus.io_wr & ~io_wr_prev & ~reset;  // Quiet while in reset

	assign low_byte = bus.addr[7:0];
	assign is_p3    = (mode == zx_pkg::MODE_P3);

	// +3 needs A14 high for 7FFD so that 1FFD does not alias it
	assign hit_7ffd = ~bus.addr[15] & ~bus.addr[1] & (bus.addr[14] | ~is_p3);
	assign hit_1ffd = is_p3 & (bus.addr[15:12] == 4'h1) & ~bus.addr[1];

	always_comb begin
		sel = '0;
		if (hit_7ffd)
			sel.sel_7ffd = 1'b1;
		else if (hit_1ffd)
			sel.sel_1ffd = 1'b1;
		else if (~bus.addr[0])
			sel.sel_ula = 1'b1;           // Any even port
		else if (low_byte == zx_pkg::PORT_COVOX)
			sel.sel_covox = 1'b1;
		else if (low_byte == zx_pkg::PORT_SD_A)
			sel.sel_sd_a = 1'b1;
		else if (low_byte == zx_pkg::PORT_SD_B)
			sel.sel_sd_b = 1'b1;
		else if (low_byte == zx_pkg::PORT_SD_C)
			sel.sel_sd_c = 1'b1;
		else if (low_byte == zx_pkg::PORT_SD_D)
			sel.sel_sd_d = 1'b1;
	end

	assign data.raw = bus.data;

endmodule

// ==== verilog/sound_regs.sv ====
//====================================================================
// ULA port FE latch, Covox/SounDrive latches and the PCM mix
// Samples are registered one cycle behind the latches
//====================================================================
module sound_regs (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  io_strobe,
	input  zx_pkg::port_sel_t     sel,
	input  logic [7:0]            data,
	output zx_pkg::ula_out_t      ula,
	output zx_pkg::audio_sample_t audio_l,
	output zx_pkg::audio_sample_t audio_r
);

	logic [7:0] sd_l0;
	logic [7:0] sd_l1;
	logic [7:0] sd_r0;
	logic [7:0] sd_r1;

	// Weighted sum, peaks at 14304 so 15 bits never wrap
	function automatic zx_pkg::audio_sample_t mix(input logic [7:0] a, input logic [7:0] b,
			input logic ear, input logic mic);
		zx_pkg::audio_sample_t sum;
		sum = {3'd0, a, 4'd0} + {3'd0, b, 4'd0};
		sum = sum + {2'd0, ear, 12'd0} + {3'd0, mic, 11'd0};
		return sum;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ula   <= '0;
			sd_l0 <= '0;
			sd_l1 <= '0;
			sd_r0 <= '0;
			sd_r1 <= '0;
		end else if (io_strobe) begin
			if (sel.sel_ula) begin
				ula.border <= data[2:0];
				ula.ear    <= data[4];
				ula.mic    <= data[3];
			end
			// Covox hits all four channels at once
			if (sel.sel_covox | sel.sel_sd_a)
				sd_l0 <= data;
			if (sel.sel_covox | sel.sel_sd_b)
				sd_l1 <= data;
			if (sel.sel_covox | sel.sel_sd_c)
				sd_r0 <= data;
			if (sel.sel_covox | sel.sel_sd_d)
				sd_r1 <= data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= mix(sd_l0, sd_l1, ula.ear, ula.mic);
			audio_r <= mix(sd_r0, sd_r1, ula.ear, ula.mic);
		end
	end

endmodule

// ==== verilog/zx_bus_top.sv ====
//====================================================================
// Spectrum CPU-side paging and I/O core, top level
// Feed one bus sample per clk_sys cycle, mem_mode is read in reset
//====================================================================
module zx_bus_top #(
	parameter zx_pkg::sdram_addr_t ROM_BASE = 24'h200000  // Start of ROM area
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zx_pkg::cpu_bus_t      bus,
	input  zx_pkg::mem_mode_e     mem_mode,
	output zx_pkg::sdram_addr_t   ram_addr,
	output logic                  ram_we,
	output zx_pkg::ula_out_t      ula,
	output zx_pkg::audio_sample_t audio_l,
	output zx_pkg::audio_sample_t audio_r
);

	logic                io_strobe;
	zx_pkg::port_sel_t   sel;
	zx_pkg::page_word_u  page_data;
	zx_pkg::page_state_t state;

	port_decode u_port_decode (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus       (bus),
		.mode      (state.mode),    // Registered mode, not the raw setting
		.io_strobe (io_strobe),
		.sel       (sel),
		.data      (page_data)
	);

	paging_regs u_paging_regs (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_strobe (io_strobe),
		.sel       (sel),
		.data      (page_data),
		.mem_mode  (mem_mode),
		.state     (state)
	);

	sound_regs u_sound_regs (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_strobe (io_strobe),
		.sel       (sel),
		.data      (page_data.raw),
		.ula       (ula),
		.audio_l   (audio_l),
		.audio_r   (audio_r)
	);

	mem_map #(.ROM_BASE(ROM_BASE)) u_mem_map (
		.bus      (bus),
		.state    (state),
		.ram_addr (ram_addr),
		.ram_we   (ram_we)
	);

endmodule

// ==== verilog/zx_pkg.sv ====
//====================================================================
// Types and constants shared by the Spectrum bus core
// Every module refers to these through zx_pkg:: scoped names
//====================================================================
package zx_pkg;

	// One Z80 bus sample, all levels active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        io_wr;  // IORQ and WR, no M1
		logic        mreq;
		logic        wr;
	} cpu_bus_t;

	typedef enum logic [1:0] {
		MODE_128 = 2'd0,
		MODE_48  = 2'd1,
		MODE_P3  = 2'd2
	} mem_mode_e;

	// Port hits for the current I/O cycle, at most one set
	typedef struct packed {
		logic sel_7ffd;
		logic sel_1ffd;
		logic sel_ula;
		logic sel_covox;
		logic sel_sd_a;
		logic sel_sd_b;
		logic sel_sd_c;
		logic sel_sd_d;
	} port_sel_t;

	//================================================================
	// Paging words
	//================================================================
	typedef struct packed {
		logic [1:0] spare;
		logic       lock;     // Latches until reset
		logic       rom_sel;
		logic       screen;
		logic [2:0] bank;     // RAM bank at C000
	} view_7ffd_t;

	// Bit 1 of special_cfg is also the high ROM select in normal paging
	typedef struct packed {
		logic [3:0] spare;
		logic       motor;
		logic [1:0] special_cfg;
		logic       special;  // All-RAM map
	} view_1ffd_t;

	typedef union packed {
		view_7ffd_t  view_7ffd;
		view_1ffd_t  view_1ffd;
		logic [7:0]  raw;
	} page_word_u;

	typedef struct packed {
		page_word_u w7ffd;
		page_word_u w1ffd;
		mem_mode_e  mode;
	} page_state_t;

	typedef logic [23:0] sdram_addr_t;
	typedef logic [14:0] audio_sample_t;

	typedef struct packed {
		logic [2:0] border;
		logic       ear;
		logic       mic;
	} ula_out_t;

	// Low address bytes of the DAC ports
	localparam logic [7:0] PORT_COVOX = 8'hFB;
	localparam logic [7:0] PORT_SD_A  = 8'h0F;
	localparam logic [7:0] PORT_SD_B  = 8'h1F;
	localparam logic [7:0] PORT_SD_C  = 8'h4F;
	localparam logic [7:0] PORT_SD_D  = 8'h5F;

	localparam int BANK_BITS = 14;  // 16K per bank

endpackage
